/* Makefile */
# Verilator build and run of the alu testbench

VERILATOR ?= verilator
TOP       ?= tb_alu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation passed

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)

/* alu_adder.sv */
// lane partitioned adder with per-byte carry break, subtract and abs negation
`timescale 1ns/1ns

module alu_adder #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input  logic [data_width_p-1:0] operand_a_i,
  input  logic [data_width_p-1:0] operand_b_i,
  input  alu_pkg::vec_mode_e      vector_mode_i,
  input  logic                    negate_i,
  input  logic                    abs_i,
  output logic [data_width_p-1:0] sum_o
);

  localparam int n_bytes = data_width_p / alu_pkg::byte_w;
  // each byte gets one extra carry control bit below it
  localparam int slice_w = alu_pkg::byte_w + 1;
  localparam int ext_w   = n_bytes * slice_w;

  logic [data_width_p-1:0] op_a;
  logic [data_width_p-1:0] op_b;
  logic                    inject;
  logic [n_bytes-1:0]      lane_start;
  logic [ext_w-1:0]        ext_a;
  logic [ext_w-1:0]        ext_b;
  logic [ext_w-1:0]        ext_sum;

  // abs: 0 - a, i.e. ~a + 0 + 1
  assign op_a   = abs_i ? ~operand_a_i : operand_a_i;
  assign op_b   = abs_i ? '0 : (negate_i ? ~operand_b_i : operand_b_i);
  assign inject = negate_i | abs_i;

  // bytes that open a new lane
  always_comb begin
    for (int i = 0; i < n_bytes; i++) begin
      case (vector_mode_i)
        alu_pkg::vec_mode8:  lane_start[i] = 1'b1;
        alu_pkg::vec_mode16: lane_start[i] = (i % 2 == 0);
        default:             lane_start[i] = (i == 0);
      endcase
    end
  end

  ////////////////////////////////////////
  // expanded operands
  ////////////////////////////////////////

  for (genvar g = 0; g < n_bytes; g++) begin : gen_slice
    // lane start, no inject: 0+0 swallows the incoming carry
    // lane start, inject: 1+1 always carries the plus-one
    // inside a lane: 1+0 passes the carry on
    assign ext_a[g*slice_w] = lane_start[g] ? inject : 1'b1;
    assign ext_b[g*slice_w] = lane_start[g] & inject;

    assign ext_a[g*slice_w+1 +: alu_pkg::byte_w] = op_a[g*alu_pkg::byte_w +: alu_pkg::byte_w];
    assign ext_b[g*slice_w+1 +: alu_pkg::byte_w] = op_b[g*alu_pkg::byte_w +: alu_pkg::byte_w];

    // drop the control bits again
    assign sum_o[g*alu_pkg::byte_w +: alu_pkg::byte_w] =
      ext_sum[g*slice_w+1 +: alu_pkg::byte_w];
  end

  // one carry chain, cut at lane starts
  assign ext_sum = ext_a + ext_b;

endmodule

/* alu_compare.sv */
// per-byte equal/greater, lane chaining, compare masks and min/max/abs selection
`timescale 1ns/1ns

module alu_compare #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input  logic [data_width_p-1:0] operand_a_i,
  input  logic [data_width_p-1:0] operand_b_i,
  input  logic [data_width_p-1:0] neg_a_i,
  input  alu_pkg::vec_mode_e      vector_mode_i,
  input  logic                    cmp_signed_i,
  input  alu_pkg::cmp_cond_e      cmp_cond_i,
  input  logic                    do_min_i,
  input  logic                    abs_i,
  output logic [data_width_p-1:0] cmp_mask_o,
  output logic [data_width_p-1:0] minmax_o,
  output logic                    cmp_flag_o
);

  localparam int bw      = alu_pkg::byte_w;
  localparam int n_bytes = data_width_p / bw;

  logic [data_width_p-1:0] cmp_b;
  logic [n_bytes-1:0]      lane_start;
  logic [n_bytes-1:0]      lane_top;
  logic [n_bytes-1:0]      byte_eq;
  logic [n_bytes-1:0]      byte_gt;
  logic [n_bytes-1:0]      acc_eq;
  logic [n_bytes-1:0]      acc_gt;
  logic [n_bytes-1:0]      is_eq;
  logic [n_bytes-1:0]      is_gt;
  logic [n_bytes-1:0]      cmp_res;
  logic [n_bytes-1:0]      sel_a;

  // abs compares a against zero
  assign cmp_b = abs_i ? '0 : operand_b_i;

  // first and last byte of every lane
  always_comb begin
    for (int i = 0; i < n_bytes; i++) begin
      case (vector_mode_i)
        alu_pkg::vec_mode8: begin
          lane_start[i] = 1'b1;
          lane_top[i]   = 1'b1;
        end
        alu_pkg::vec_mode16: begin
          lane_start[i] = (i % 2 == 0);
          lane_top[i]   = (i % 2 == 1);
        end
        default: begin
          lane_start[i] = (i == 0);
          lane_top[i]   = (i == n_bytes - 1);
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // byte compares
  ////////////////////////////////////////

  for (genvar g = 0; g < n_bytes; g++) begin : gen_byte
    logic sign_a;
    logic sign_b;
    // the sign only matters on the top byte of a lane
    assign sign_a     = cmp_signed_i & lane_top[g] & operand_a_i[g*bw+bw-1];
    assign sign_b     = cmp_signed_i & lane_top[g] & cmp_b[g*bw+bw-1];
    assign byte_eq[g] = (operand_a_i[g*bw +: bw] == cmp_b[g*bw +: bw]);
    assign byte_gt[g] = $signed({sign_a, operand_a_i[g*bw +: bw]}) >
                        $signed({sign_b, cmp_b[g*bw +: bw]});
  end

  // chain bytes upward inside a lane, then copy the top result down the lane
  always_comb begin : lane_chain
    logic eq_run;
    logic gt_run;
    eq_run = 1'b1;
    gt_run = 1'b0;
    for (int i = 0; i < n_bytes; i++) begin
      if (lane_start[i]) begin
        eq_run = 1'b1;
        gt_run = 1'b0;
      end
      // a higher byte decides unless it is equal
      gt_run    = byte_gt[i] | (byte_eq[i] & gt_run);
      eq_run    = byte_eq[i] & eq_run;
      acc_eq[i] = eq_run;
      acc_gt[i] = gt_run;
    end
    for (int i = n_bytes - 1; i >= 0; i--) begin
      if (lane_top[i]) begin
        eq_run = acc_eq[i];
        gt_run = acc_gt[i];
      end
      is_eq[i] = eq_run;
      is_gt[i] = gt_run;
    end
  end

  ////////////////////////////////////////
  // masks and selection
  ////////////////////////////////////////

  always_comb begin
    case (cmp_cond_i)
      alu_pkg::cond_ne:    cmp_res = ~is_eq;
      alu_pkg::cond_gt_ge: cmp_res = is_gt | is_eq;
      alu_pkg::cond_lt:    cmp_res = ~(is_gt | is_eq);
      default:             cmp_res = is_eq;
    endcase
  end

  // scalar flag from the top lane
  assign cmp_flag_o = cmp_res[n_bytes-1];

  // min keeps a when a is not greater
  assign sel_a = is_gt ^ {n_bytes{do_min_i}};

  for (genvar g = 0; g < n_bytes; g++) begin : gen_out
    assign cmp_mask_o[g*bw +: bw] = {bw{cmp_res[g]}};
    assign minmax_o[g*bw +: bw]   = sel_a[g] ? operand_a_i[g*bw +: bw] :
                                    (abs_i ? neg_a_i[g*bw +: bw] : operand_b_i[g*bw +: bw]);
  end

endmodule

/* alu_decode.sv */
// operator decoder: execute unit controls and result select
`timescale 1ns/1ns

module alu_decode (
  input  alu_pkg::alu_op_e   operator_i,
  input  alu_pkg::vec_mode_e vector_mode_i,
  output logic               negate_o,
  output logic               abs_o,
  output logic               shift_left_o,
  output logic               shift_arith_o,
  output logic               rotate_o,
  output logic               cmp_signed_o,
  output alu_pkg::cmp_cond_e cmp_cond_o,
  output logic               do_min_o,
  output alu_pkg::res_sel_e  res_sel_o
);

  ////////////////////////////////////////
  // opcode to control levels
  ////////////////////////////////////////

  always_comb begin
    // idle values, logic ops need nothing else
    negate_o      = 1'b0;
    abs_o         = 1'b0;
    shift_left_o  = 1'b0;
    shift_arith_o = 1'b0;
    rotate_o      = 1'b0;
    cmp_signed_o  = 1'b0;
    cmp_cond_o    = alu_pkg::cond_eq;
    do_min_o      = 1'b0;
    res_sel_o     = alu_pkg::res_logic;

    case (operator_i)
      alu_pkg::alu_add: res_sel_o = alu_pkg::res_adder;
      alu_pkg::alu_sub: begin
        // b inverted, plus-one injected per lane
        negate_o  = 1'b1;
        res_sel_o = alu_pkg::res_adder;
      end

      // shifter group
      alu_pkg::alu_sll: begin
        shift_left_o = 1'b1;
        res_sel_o    = alu_pkg::res_shift;
      end
      alu_pkg::alu_srl: res_sel_o = alu_pkg::res_shift;
      alu_pkg::alu_sra: begin
        shift_arith_o = 1'b1;
        res_sel_o     = alu_pkg::res_shift;
      end
      alu_pkg::alu_ror: begin
        // lane modes fall back to a logical right shift
        rotate_o  = (vector_mode_i == alu_pkg::vec_mode32);
        res_sel_o = alu_pkg::res_shift;
      end

      // lane compares, mask written to the result
      alu_pkg::alu_eq: res_sel_o = alu_pkg::res_cmp;
      alu_pkg::alu_ne: begin
        cmp_cond_o = alu_pkg::cond_ne;
        res_sel_o  = alu_pkg::res_cmp;
      end
      alu_pkg::alu_lts, alu_pkg::alu_ltu: begin
        cmp_signed_o = (operator_i == alu_pkg::alu_lts);
        cmp_cond_o   = alu_pkg::cond_lt;
        res_sel_o    = alu_pkg::res_cmp;
      end
      alu_pkg::alu_ges, alu_pkg::alu_geu: begin
        cmp_signed_o = (operator_i == alu_pkg::alu_ges);
        cmp_cond_o   = alu_pkg::cond_gt_ge;
        res_sel_o    = alu_pkg::res_cmp;
      end

      // min/max pick a or b per lane from the greater bit
      alu_pkg::alu_min, alu_pkg::alu_minu: begin
        cmp_signed_o = (operator_i == alu_pkg::alu_min);
        do_min_o     = 1'b1;
        res_sel_o    = alu_pkg::res_minmax;
      end
      alu_pkg::alu_max, alu_pkg::alu_maxu: begin
        cmp_signed_o = (operator_i == alu_pkg::alu_max);
        res_sel_o    = alu_pkg::res_minmax;
      end
      alu_pkg::alu_abs: begin
        // signed a > 0 keeps a, otherwise the negated word
        abs_o        = 1'b1;
        cmp_signed_o = 1'b1;
        res_sel_o    = alu_pkg::res_minmax;
      end
      default: ;
    endcase
  end

endmodule

/* alu_pkg.sv */
// operator, vector mode, result select and compare condition types, lane width constants
package alu_pkg;

  ////////////////////////////////////////
  // lane geometry
  ////////////////////////////////////////

  // smallest lane, also the unit of the carry chain
  localparam int byte_w = 8;

  // a 16-bit lane spans two bytes
  localparam int half_w = 2 * byte_w;

  // full word width that the top level passes down
  localparam int default_data_width = 32;

  ////////////////////////////////////////
  // operators
  ////////////////////////////////////////

  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_and  = 5'd2,
    alu_or   = 5'd3,
    alu_xor  = 5'd4,
    alu_sll  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_ror  = 5'd8,
    alu_eq   = 5'd9,
    alu_ne   = 5'd10,
    alu_lts  = 5'd11,
    alu_ltu  = 5'd12,
    alu_ges  = 5'd13,
    alu_geu  = 5'd14,
    alu_min  = 5'd15,
    alu_minu = 5'd16,
    alu_max  = 5'd17,
    alu_maxu = 5'd18,
    alu_abs  = 5'd19
  } alu_op_e;

  // lane split of the word; mode32 means one lane over the full width
  typedef enum logic [1:0] {
    vec_mode32 = 2'b00,
    vec_mode16 = 2'b10,
    vec_mode8  = 2'b11
  } vec_mode_e;

  // source of the registered result word
  typedef enum logic [2:0] {
    res_logic  = 3'd0,
    res_adder  = 3'd1,
    res_shift  = 3'd2,
    res_cmp    = 3'd3,
    res_minmax = 3'd4
  } res_sel_e;

  // lane condition that turns into the compare mask
  typedef enum logic [1:0] {
    cond_eq    = 2'd0,
    cond_ne    = 2'd1,
    cond_gt_ge = 2'd2,
    cond_lt    = 2'd3
  } cmp_cond_e;

endpackage

/* alu_props.sv */
// concurrent assertions on the alu top level ports, bound to alu_top
`timescale 1ns/1ns

module alu_props #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input logic                    clk,
  input logic                    reset_i,
  input logic                    enable_i,
  input logic                    valid_i,
  input logic [data_width_p-1:0] result_i
);

  // valid low through reset and in the first cycle after it
  a_reset_valid: assert property (@(posedge clk) reset_i |=> !valid_i)
    else $error("valid_o high in the cycle after a reset cycle");

  // exactly one cycle from enable to valid
  a_valid_follows: assert property (@(posedge clk) disable iff (reset_i)
    valid_i == $past(enable_i))
    else $error("valid_o does not follow enable_i by one cycle");

  a_result_hold: assert property (@(posedge clk) disable iff (reset_i)
    !valid_i |-> $stable(result_i))
    else $error("result_o changed without valid_o");

endmodule

bind alu_top alu_props #(.data_width_p(data_width_p)) u_props (
  .clk     (clk),
  .reset_i (reset_i),
  .enable_i(enable_i),
  .valid_i (valid_o),
  .result_i(result_o)
);

/* alu_result.sv */
// result mux, output register and valid pulse
`timescale 1ns/1ns

module alu_result #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    enable_i,
  input  alu_pkg::res_sel_e       res_sel_i,
  input  alu_pkg::alu_op_e        operator_i,
  input  logic [data_width_p-1:0] operand_a_i,
  input  logic [data_width_p-1:0] operand_b_i,
  input  logic [data_width_p-1:0] sum_i,
  input  logic [data_width_p-1:0] shift_i,
  input  logic [data_width_p-1:0] cmp_mask_i,
  input  logic [data_width_p-1:0] minmax_i,
  input  logic                    cmp_flag_i,
  output logic [data_width_p-1:0] result_o,
  output logic                    comparison_result_o,
  output logic                    valid_o
);

  logic [data_width_p-1:0] logic_word;
  logic [data_width_p-1:0] result_d;

  // bitwise ops, and is the default
  always_comb begin
    case (operator_i)
      alu_pkg::alu_or:  logic_word = operand_a_i | operand_b_i;
      alu_pkg::alu_xor: logic_word = operand_a_i ^ operand_b_i;
      default:          logic_word = operand_a_i & operand_b_i;
    endcase
  end

  always_comb begin
    case (res_sel_i)
      alu_pkg::res_adder:  result_d = sum_i;
      alu_pkg::res_shift:  result_d = shift_i;
      alu_pkg::res_cmp:    result_d = cmp_mask_i;
      alu_pkg::res_minmax: result_d = minmax_i;
      default:             result_d = logic_word;
    endcase
  end

  ////////////////////////////////////////
  // output stage
  ////////////////////////////////////////

  // one cycle from enable to valid, outputs hold between operations
  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_o            <= '0;
      comparison_result_o <= 1'b0;
      valid_o             <= 1'b0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o            <= result_d;
        comparison_result_o <= cmp_flag_i;
      end
    end
  end

endmodule

/* alu_shifter.sv */
// per-lane right shifter with bit reversal for left shifts and full width rotate
`timescale 1ns/1ns

module alu_shifter #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input  logic [data_width_p-1:0] operand_a_i,
  input  logic [data_width_p-1:0] operand_b_i,
  input  alu_pkg::vec_mode_e      vector_mode_i,
  input  logic                    shift_left_i,
  input  logic                    shift_arith_i,
  input  logic                    rotate_i,
  output logic [data_width_p-1:0] shift_o
);

  localparam int amt_w    = $clog2(data_width_p);
  localparam int amt16_w  = $clog2(alu_pkg::half_w);
  localparam int amt8_w   = $clog2(alu_pkg::byte_w);
  localparam int n_halves = data_width_p / alu_pkg::half_w;
  localparam int n_bytes  = data_width_p / alu_pkg::byte_w;

  logic [data_width_p-1:0]   a_rev;
  logic [data_width_p-1:0]   op_a;
  logic [data_width_p-1:0]   amt;
  logic [2*data_width_p-1:0] ext_a;
  logic [2*data_width_p-1:0] full_shift;
  logic [data_width_p-1:0]   right_res;
  logic [data_width_p-1:0]   left_res;

  ////////////////////////////////////////
  // operand preparation
  ////////////////////////////////////////

  // left shift is a right shift of the reversed word
  always_comb begin
    for (int i = 0; i < data_width_p; i++) begin
      a_rev[i]    = operand_a_i[data_width_p-1-i];
      left_res[i] = right_res[data_width_p-1-i];
    end
  end

  assign op_a = shift_left_i ? a_rev : operand_a_i;

  // reversal also flips the lane order, so the amounts follow
  always_comb begin
    amt = operand_b_i;
    if (shift_left_i) begin
      case (vector_mode_i)
        alu_pkg::vec_mode16: begin
          for (int j = 0; j < n_halves; j++) begin
            amt[j*alu_pkg::half_w +: alu_pkg::half_w] =
              operand_b_i[(n_halves-1-j)*alu_pkg::half_w +: alu_pkg::half_w];
          end
        end
        alu_pkg::vec_mode8: begin
          for (int j = 0; j < n_bytes; j++) begin
            amt[j*alu_pkg::byte_w +: alu_pkg::byte_w] =
              operand_b_i[(n_bytes-1-j)*alu_pkg::byte_w +: alu_pkg::byte_w];
          end
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // right shift per lane
  ////////////////////////////////////////

  // rotate doubles a, otherwise the upper half is the fill
  assign ext_a      = rotate_i ? {op_a, op_a} :
                      {{data_width_p{shift_arith_i & op_a[data_width_p-1]}}, op_a};
  assign full_shift = ext_a >> amt[amt_w-1:0];

  always_comb begin : lane_shift
    logic [alu_pkg::half_w:0] lane16;
    logic [alu_pkg::byte_w:0] lane8;
    right_res = full_shift[data_width_p-1:0];
    case (vector_mode_i)
      alu_pkg::vec_mode16: begin
        for (int j = 0; j < n_halves; j++) begin
          // sign extend by one bit, then arithmetic shift
          lane16 = {shift_arith_i & op_a[j*alu_pkg::half_w+alu_pkg::half_w-1],
                    op_a[j*alu_pkg::half_w +: alu_pkg::half_w]};
          lane16 = $signed(lane16) >>> amt[j*alu_pkg::half_w +: amt16_w];
          right_res[j*alu_pkg::half_w +: alu_pkg::half_w] = lane16[alu_pkg::half_w-1:0];
        end
      end
      alu_pkg::vec_mode8: begin
        for (int j = 0; j < n_bytes; j++) begin
          lane8 = {shift_arith_i & op_a[j*alu_pkg::byte_w+alu_pkg::byte_w-1],
                   op_a[j*alu_pkg::byte_w +: alu_pkg::byte_w]};
          lane8 = $signed(lane8) >>> amt[j*alu_pkg::byte_w +: amt8_w];
          right_res[j*alu_pkg::byte_w +: alu_pkg::byte_w] = lane8[alu_pkg::byte_w-1:0];
        end
      end
      default: ;
    endcase
  end

  // undo the reversal for left shifts
  assign shift_o = shift_left_i ? left_res : right_res;

endmodule

/* alu_top.sv */
// packed SIMD alu top level: decode, execute units and result stage
`timescale 1ns/1ns

module alu_top #(
  parameter int data_width_p = alu_pkg::default_data_width
) (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    enable_i,
  input  alu_pkg::alu_op_e        operator_i,
  input  alu_pkg::vec_mode_e      vector_mode_i,
  input  logic [data_width_p-1:0] operand_a_i,
  input  logic [data_width_p-1:0] operand_b_i,
  output logic [data_width_p-1:0] result_o,
  output logic                    comparison_result_o,
  output logic                    valid_o
);

  // decode controls
  logic               negate;
  logic               abs_op;
  logic               shift_left;
  logic               shift_arith;
  logic               rotate;
  logic               cmp_signed;
  alu_pkg::cmp_cond_e cmp_cond;
  logic               do_min;
  alu_pkg::res_sel_e  res_sel;

  // execute words
  logic [data_width_p-1:0] sum;
  logic [data_width_p-1:0] shift_word;
  logic [data_width_p-1:0] cmp_mask;
  logic [data_width_p-1:0] minmax;
  logic                    cmp_flag;

  alu_decode u_decode (
    .operator_i   (operator_i),
    .vector_mode_i(vector_mode_i),
    .negate_o     (negate),
    .abs_o        (abs_op),
    .shift_left_o (shift_left),
    .shift_arith_o(shift_arith),
    .rotate_o     (rotate),
    .cmp_signed_o (cmp_signed),
    .cmp_cond_o   (cmp_cond),
    .do_min_o     (do_min),
    .res_sel_o    (res_sel)
  );

  alu_adder #(.data_width_p(data_width_p)) u_adder (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .vector_mode_i(vector_mode_i),
    .negate_i     (negate),
    .abs_i        (abs_op),
    .sum_o        (sum)
  );

  alu_shifter #(.data_width_p(data_width_p)) u_shifter (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .vector_mode_i(vector_mode_i),
    .shift_left_i (shift_left),
    .shift_arith_i(shift_arith),
    .rotate_i     (rotate),
    .shift_o      (shift_word)
  );

  // the adder word is -a during abs
  alu_compare #(.data_width_p(data_width_p)) u_compare (
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .neg_a_i      (sum),
    .vector_mode_i(vector_mode_i),
    .cmp_signed_i (cmp_signed),
    .cmp_cond_i   (cmp_cond),
    .do_min_i     (do_min),
    .abs_i        (abs_op),
    .cmp_mask_o   (cmp_mask),
    .minmax_o     (minmax),
    .cmp_flag_o   (cmp_flag)
  );

  alu_result #(.data_width_p(data_width_p)) u_result (
    .clk                (clk),
    .reset_i            (reset_i),
    .enable_i           (enable_i),
    .res_sel_i          (res_sel),
    .operator_i         (operator_i),
    .operand_a_i        (operand_a_i),
    .operand_b_i        (operand_b_i),
    .sum_i              (sum),
    .shift_i            (shift_word),
    .cmp_mask_i         (cmp_mask),
    .minmax_i           (minmax),
    .cmp_flag_i         (cmp_flag),
    .result_o           (result_o),
    .comparison_result_o(comparison_result_o),
    .valid_o            (valid_o)
  );

endmodule

/* tb.f */
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_adder.sv
alu_shifter.sv
alu_compare.sv
alu_result.sv
alu_top.sv
alu_props.sv
tb_alu.sv

/* tb_alu_model.svh */
// reference model of the packed SIMD alu: lane helpers and the word model
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// all ones over the low lw bits
function automatic logic [31:0] lane_mask(int lw);
  return (lw == 32) ? 32'hffff_ffff : ((32'd1 << lw) - 32'd1);
endfunction

// sign extend a lane value of lw bits to the full word
function automatic logic signed [31:0] sext_lane(logic [31:0] v, int lw);
  logic [31:0] up;
  up = v << (32 - lw);
  return $signed(up) >>> (32 - lw);
endfunction

// lane condition of the compare ops, eq for everything else
function automatic logic lane_cond(alu_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b,
                                   int lw);
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  sa = sext_lane(a, lw);
  sb = sext_lane(b, lw);
  case (op)
    alu_pkg::alu_ne:  return a != b;
    alu_pkg::alu_lts: return sa < sb;
    alu_pkg::alu_ltu: return a < b;
    alu_pkg::alu_ges: return sa >= sb;
    alu_pkg::alu_geu: return a >= b;
    default:          return a == b;
  endcase
endfunction

// one lane of the result, inputs are lane values in the low lw bits
function automatic logic [31:0] lane_result(alu_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b, int lw);
  logic [31:0]        amt;
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  logic [31:0]        r;
  // shift amount is the low log2(lw) bits of the lane
  amt = b & 32'(lw - 1);
  sa  = sext_lane(a, lw);
  sb  = sext_lane(b, lw);
  case (op)
    alu_pkg::alu_add:  r = a + b;
    alu_pkg::alu_sub:  r = a - b;
    alu_pkg::alu_and:  r = a & b;
    alu_pkg::alu_or:   r = a | b;
    alu_pkg::alu_xor:  r = a ^ b;
    alu_pkg::alu_sll:  r = a << amt;
    alu_pkg::alu_srl:  r = a >> amt;
    alu_pkg::alu_sra:  r = sa >>> amt;
    // rotate exists only over the full word
    alu_pkg::alu_ror:  r = (lw == 32) ? ((a >> amt) | (a << (32 - amt))) : (a >> amt);
    alu_pkg::alu_eq, alu_pkg::alu_ne, alu_pkg::alu_lts,
    alu_pkg::alu_ltu, alu_pkg::alu_ges, alu_pkg::alu_geu:
      r = lane_cond(op, a, b, lw) ? lane_mask(lw) : 32'd0;
    alu_pkg::alu_min:  r = (sa <= sb) ? a : b;
    alu_pkg::alu_minu: r = (a <= b) ? a : b;
    alu_pkg::alu_max:  r = (sa > sb) ? a : b;
    alu_pkg::alu_maxu: r = (a > b) ? a : b;
    // most negative value wraps back onto itself
    alu_pkg::alu_abs:  r = (sa < 0) ? (32'd0 - a) : a;
    default:           r = 32'd0;
  endcase
  return r & lane_mask(lw);
endfunction

// whole word, flag from the top lane, flag only defined for compares
function automatic void compute_expected(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                                         logic [31:0] a, logic [31:0] b,
                                         output logic [31:0] res, output logic flag,
                                         output logic flag_known);
  int          lw;
  logic [31:0] la;
  logic [31:0] lb;
  case (mode)
    alu_pkg::vec_mode16: lw = 16;
    alu_pkg::vec_mode8:  lw = 8;
    default:             lw = 32;
  endcase
  res  = 32'd0;
  flag = 1'b0;
  for (int l = 0; l < 32 / lw; l++) begin
    la   = (a >> (l * lw)) & lane_mask(lw);
    lb   = (b >> (l * lw)) & lane_mask(lw);
    res  = res | (lane_result(op, la, lb, lw) << (l * lw));
    // last pass is the top lane
    flag = lane_cond(op, la, lb, lw);
  end
  flag_known = op inside {alu_pkg::alu_eq, alu_pkg::alu_ne, alu_pkg::alu_lts,
                          alu_pkg::alu_ltu, alu_pkg::alu_ges, alu_pkg::alu_geu};
endfunction

`endif

/* tb_alu.sv */
// testbench for the packed SIMD alu: clock, reset, LFSR stimulus, scoreboard and report
`timescale 1ns/1ns

module tb_alu;

  localparam int n_ops       = 400;
  localparam int drain_limit = 50;

  logic               clk;
  logic               reset_i;
  logic               enable_i;
  alu_pkg::alu_op_e   operator_i;
  alu_pkg::vec_mode_e vector_mode_i;
  logic [31:0]        operand_a_i;
  logic [31:0]        operand_b_i;
  logic [31:0]        result_o;
  logic               comparison_result_o;
  logic               valid_o;

  // scoreboard, one entry per issued operation
  logic [31:0]      exp_res_q[$];
  logic             exp_flag_q[$];
  logic             exp_known_q[$];
  alu_pkg::alu_op_e exp_op_q[$];

  int          checks;
  int          value_errors;
  int          other_errors;
  logic [15:0] lfsr_state;

  `include "tb_alu_model.svh"

  alu_top u_dut (
    .clk                (clk),
    .reset_i            (reset_i),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .vector_mode_i      (vector_mode_i),
    .operand_a_i        (operand_a_i),
    .operand_b_i        (operand_b_i),
    .result_o           (result_o),
    .comparison_result_o(comparison_result_o),
    .valid_o            (valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    logic        fb;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v          = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic alu_pkg::vec_mode_e pick_mode();
    case (take_bits(2))
      32'd1:   return alu_pkg::vec_mode16;
      32'd2:   return alu_pkg::vec_mode8;
      default: return alu_pkg::vec_mode32;
    endcase
  endfunction

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("error at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  // drive one operation and queue its expected result
  task automatic issue(alu_pkg::alu_op_e op, alu_pkg::vec_mode_e mode,
                       logic [31:0] a, logic [31:0] b);
    logic [31:0] r;
    logic        f;
    logic        k;
    @(posedge clk);
    enable_i      <= 1'b1;
    operator_i    <= op;
    vector_mode_i <= mode;
    operand_a_i   <= a;
    operand_b_i   <= b;
    compute_expected(op, mode, a, b, r, f, k);
    exp_res_q.push_back(r);
    exp_flag_q.push_back(f);
    exp_known_q.push_back(k);
    exp_op_q.push_back(op);
  endtask

  // no enable, inputs keep moving so a missed hold shows up
  task automatic idle_cycle();
    @(posedge clk);
    enable_i    <= 1'b0;
    operand_a_i <= take_bits(32);
    operand_b_i <= take_bits(32);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    alu_pkg::alu_op_e   op;
    alu_pkg::vec_mode_e mode;
    logic [31:0]        a;
    logic [31:0]        b;
    int                 cycles;
    lfsr_state    = 16'd11162;
    checks        = 0;
    value_errors  = 0;
    other_errors  = 0;
    reset_i       = 1'b1;
    // an eq with a nonzero mask and flag offered during reset must leave no trace
    enable_i      = 1'b1;
    operator_i    = alu_pkg::alu_eq;
    vector_mode_i = alu_pkg::vec_mode32;
    operand_a_i   = 32'h5a5a_5a5a;
    operand_b_i   = 32'h5a5a_5a5a;
    repeat (3) @(posedge clk);
    enable_i <= 1'b0;
    @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_value("valid_o after reset", {31'd0, valid_o}, 32'd0);
    check_value("result_o after reset", result_o, 32'd0);
    check_value("flag after reset", {31'd0, comparison_result_o}, 32'd0);

    // corner cases, issued back to back
    issue(alu_pkg::alu_abs, alu_pkg::vec_mode32, 32'h8000_0000, 32'd0);
    issue(alu_pkg::alu_abs, alu_pkg::vec_mode16, 32'h8000_ffff, 32'd0);
    issue(alu_pkg::alu_abs, alu_pkg::vec_mode8, 32'h80ff_017f, 32'd0);
    issue(alu_pkg::alu_lts, alu_pkg::vec_mode8, 32'h80ff_7f01, 32'h0101_8080);
    issue(alu_pkg::alu_ltu, alu_pkg::vec_mode8, 32'h80ff_7f01, 32'h0101_8080);
    issue(alu_pkg::alu_add, alu_pkg::vec_mode8, 32'hffff_ffff, 32'h0101_0101);
    issue(alu_pkg::alu_sub, alu_pkg::vec_mode16, 32'h0000_0001, 32'h0001_0002);
    issue(alu_pkg::alu_sra, alu_pkg::vec_mode16, 32'h8000_f00f, 32'h0004_000f);
    issue(alu_pkg::alu_ror, alu_pkg::vec_mode32, 32'h1234_5678, 32'h0000_0008);
    issue(alu_pkg::alu_ror, alu_pkg::vec_mode16, 32'h1234_5678, 32'h0004_0008);
    idle_cycle();
    idle_cycle();

    // random mix, about one idle cycle in four
    for (int i = 0; i < n_ops; i++) begin
      if (take_bits(2) != 32'd0) begin
        op   = alu_pkg::alu_op_e'(5'(take_bits(5) % 32'd20));
        mode = pick_mode();
        a    = take_bits(32);
        b    = take_bits(32);
        // equal operands now and then for eq and min/max ties
        if (take_bits(2) == 32'd0) begin
          b = a;
        end
        issue(op, mode, a, b);
      end else begin
        idle_cycle();
      end
    end
    idle_cycle();

    cycles = 0;
    while (exp_res_q.size() != 0 && cycles < drain_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_res_q.size() != 0) begin
      other_errors++;
      $display("timeout: %0d results never came out of the DUT", exp_res_q.size());
    end

    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////

  // outputs sampled mid cycle, away from the edge
  initial begin : monitor
    logic [31:0]      last_res;
    logic             last_flag;
    logic [31:0]      exp_r;
    logic             exp_f;
    logic             exp_k;
    alu_pkg::alu_op_e exp_op;
    last_res  = 32'd0;
    last_flag = 1'b0;
    forever begin
      @(negedge clk);
      if (!reset_i) begin
        if (valid_o) begin
          if (exp_res_q.size() == 0) begin
            other_errors++;
            $display("valid_o went high at %0t ns with no operation pending", $time);
          end else begin
            exp_r  = exp_res_q.pop_front();
            exp_f  = exp_flag_q.pop_front();
            exp_k  = exp_known_q.pop_front();
            exp_op = exp_op_q.pop_front();
            check_value($sformatf("%s result", exp_op.name()), result_o, exp_r);
            if (exp_k) begin
              check_value($sformatf("%s flag", exp_op.name()),
                          {31'd0, comparison_result_o}, {31'd0, exp_f});
            end
            last_res  = exp_r;
            last_flag = exp_k ? exp_f : comparison_result_o;
          end
        end else begin
          // no valid, both outputs hold
          check_value("held result", result_o, last_res);
          check_value("held flag", {31'd0, comparison_result_o}, {31'd0, last_flag});
        end
      end
    end
  end

endmodule
